// File: logic/core_pkg.sv
package core_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned DIGIT_W    = 2;               // bits per serial cycle
    localparam int unsigned DIGITS     = XLEN / DIGIT_W;  // serial cycles per word
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned NUM_REGS   = 32;
    localparam int unsigned PC_STEP    = 4;

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] HALT_OPCODE   = 7'b1111111;  // custom, outside rv32i

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [DIGIT_W-1:0]    digit_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // ALU_NONE marks anything the core retires as a no-op
    typedef enum logic [2:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_DECODE,
        ST_EXECUTE,
        ST_WRITEBACK,
        ST_HALTED
    } core_state_e;

endpackage

// File: logic/serial_exec_if.sv
`timescale 1ns/1ns

interface serial_exec_if;
    import core_pkg::*;

    logic    load;       // one cycle, captures operands
    logic    step;       // held high for the digit cycles
    word_t   operand_a;
    word_t   operand_b;
    alu_op_e alu_op;
    word_t   result;

    modport seq (
        output load, step, operand_a, operand_b, alu_op,
        input  result
    );

    modport alu (
        input  load, step, operand_a, operand_b, alu_op,
        output result
    );

endinterface

// File: logic/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
    input  core_pkg::word_t     instr,
    output core_pkg::reg_addr_t rs1,
    output core_pkg::reg_addr_t rs2,
    output core_pkg::reg_addr_t rd,
    output core_pkg::word_t     imm,
    output logic                use_imm,
    output core_pkg::alu_op_e   alu_op,
    output logic                is_halt
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];
    assign imm = {{20{instr[31]}}, instr[31:20]};  // i-type, sign extended

    assign use_imm = (opcode == OPCODE_OP_IMM);
    assign is_halt = (opcode == HALT_OPCODE);

    always_comb begin
        alu_op = ALU_NONE;
        if (opcode == OPCODE_OP || opcode == OPCODE_OP_IMM) begin
            case (funct3)
                3'b000: begin
                    // funct7 bit 5 selects sub, register form only
                    if (opcode == OPCODE_OP && instr[30]) begin
                        alu_op = ALU_SUB;
                    end else begin
                        alu_op = ALU_ADD;
                    end
                end
                3'b100:  alu_op = ALU_XOR;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_AND;
                default: alu_op = ALU_NONE;  // shifts, compares retire as no-op
            endcase
        end
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                w_clk,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    output core_pkg::word_t     rdata1,
    output core_pkg::word_t     rdata2,
    input  logic                we,
    input  core_pkg::reg_addr_t rd,
    input  core_pkg::word_t     wdata
);
    import core_pkg::*;

    word_t mem [NUM_REGS];

    // x0 reads as zero whatever the array holds
    assign rdata1 = (rs1 == '0) ? '0 : mem[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : mem[rs2];

    always_ff @(posedge w_clk) begin
        if (we && rd != '0) begin
            mem[rd] <= wdata;
        end
    end

endmodule

// File: logic/serial_alu.sv
`timescale 1ns/1ns

module serial_alu (
    input logic        w_clk,
    input logic        r_rst,
    serial_exec_if.alu exec
);
    import core_pkg::*;

    word_t   opa_sr;
    word_t   opb_sr;
    word_t   result_sr;
    alu_op_e op_q;
    logic    carry;
    digit_t  b_dig;
    digit_t  sum_dig;
    digit_t  res_dig;
    logic    carry_out;

    always_comb begin
        // subtract as a + ~b + 1, the 1 comes from the carry preset
        b_dig = (op_q == ALU_SUB) ? ~opb_sr[DIGIT_W-1:0] : opb_sr[DIGIT_W-1:0];
        {carry_out, sum_dig} = {1'b0, opa_sr[DIGIT_W-1:0]} + {1'b0, b_dig} + {2'b00, carry};
        case (op_q)
            ALU_ADD, ALU_SUB: res_dig = sum_dig;
            ALU_XOR: res_dig = opa_sr[DIGIT_W-1:0] ^ opb_sr[DIGIT_W-1:0];
            ALU_OR:  res_dig = opa_sr[DIGIT_W-1:0] | opb_sr[DIGIT_W-1:0];
            ALU_AND: res_dig = opa_sr[DIGIT_W-1:0] & opb_sr[DIGIT_W-1:0];
            default: res_dig = '0;
        endcase
    end

    always_ff @(posedge w_clk) begin
        if (r_rst) begin
            carry <= 1'b0;
        end else if (exec.load) begin
            carry <= (exec.alu_op == ALU_SUB);  // carry in of the lowest digit
        end else if (exec.step) begin
            carry <= carry_out;
        end
    end

    always_ff @(posedge w_clk) begin
        if (exec.load) begin
            opa_sr <= exec.operand_a;
            opb_sr <= exec.operand_b;
            op_q   <= exec.alu_op;
        end else if (exec.step) begin
            opa_sr    <= opa_sr >> DIGIT_W;
            opb_sr    <= opb_sr >> DIGIT_W;
            result_sr <= {res_dig, result_sr[XLEN-1:DIGIT_W]};  // fills from the top
        end
    end

    assign exec.result = result_sr;

endmodule

// File: logic/pc_serial_adder.sv
`timescale 1ns/1ns

module pc_serial_adder (
    input  logic            w_clk,
    input  logic            r_rst,
    input  logic            load,
    input  logic            step,
    input  core_pkg::word_t pc,
    output core_pkg::word_t next_pc
);
    import core_pkg::*;

    word_t  pc_sr;   // low digits consumed, sum digits shifted in on top
    word_t  inc_sr;
    logic   carry;
    digit_t sum_dig;
    logic   carry_out;

    assign {carry_out, sum_dig} = {1'b0, pc_sr[DIGIT_W-1:0]} + {1'b0, inc_sr[DIGIT_W-1:0]}
                                  + {2'b00, carry};

    always_ff @(posedge w_clk) begin
        if (r_rst) begin
            carry <= 1'b0;
        end else if (load) begin
            carry <= 1'b0;
        end else if (step) begin
            carry <= carry_out;
        end
    end

    always_ff @(posedge w_clk) begin
        if (load) begin
            pc_sr  <= pc;
            inc_sr <= word_t'(PC_STEP);
        end else if (step) begin
            pc_sr  <= {sum_dig, pc_sr[XLEN-1:DIGIT_W]};
            inc_sr <= inc_sr >> DIGIT_W;
        end
    end

    assign next_pc = pc_sr;  // full pc + 4 once all digits are in

endmodule

// File: logic/core_sequencer.sv
`timescale 1ns/1ns

module core_sequencer (
    input  logic                w_clk,
    input  logic                r_rst,
    serial_exec_if.seq          exec,
    input  core_pkg::word_t     rdata1,
    input  core_pkg::word_t     rdata2,
    input  core_pkg::reg_addr_t rd,
    input  core_pkg::word_t     imm,
    input  logic                use_imm,
    input  core_pkg::alu_op_e   alu_op,
    input  logic                is_halt,
    input  core_pkg::word_t     next_pc,
    output logic                serial_load,
    output logic                serial_step,
    output core_pkg::word_t     pc,
    output logic                rf_we,
    output core_pkg::reg_addr_t rf_rd,
    output core_pkg::word_t     rf_wdata,
    output core_pkg::word_t     rout,
    output logic                retire,
    output logic                halt
);
    import core_pkg::*;

    core_state_e                state;
    logic [$clog2(DIGITS)-1:0]  cnt;       // digit index during execute
    reg_addr_t                  rd_q;
    alu_op_e                    alu_op_q;
    logic                       wr_en;

    assign serial_load = (state == ST_DECODE);
    assign serial_step = (state == ST_EXECUTE);

    assign exec.load      = serial_load;
    assign exec.step      = serial_step;
    assign exec.operand_a = rdata1;
    assign exec.operand_b = use_imm ? imm : rdata2;
    assign exec.alu_op    = alu_op;  // alu latches its own copy on load

    // alu-type instructions only, x0 never written
    assign wr_en = (state == ST_WRITEBACK) && (alu_op_q != ALU_NONE) && (rd_q != '0);

    assign rf_we    = wr_en;
    assign rf_rd    = rd_q;
    assign rf_wdata = exec.result;
    assign halt     = (state == ST_HALTED);

    always_ff @(posedge w_clk) begin
        if (r_rst) begin
            state    <= ST_DECODE;
            cnt      <= '0;
            pc       <= '0;
            rout     <= '0;
            retire   <= 1'b0;
            rd_q     <= '0;
            alu_op_q <= ALU_NONE;
        end else begin
            retire <= 1'b0;
            case (state)
                ST_DECODE: begin
                    rd_q     <= rd;
                    alu_op_q <= alu_op;
                    cnt      <= '0;
                    if (is_halt) begin
                        state <= ST_HALTED;  // pc stays on the halt word
                    end else begin
                        state <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: begin
                    cnt <= cnt + 1'b1;
                    if (&cnt) begin  // last digit
                        state <= ST_WRITEBACK;
                    end
                end
                ST_WRITEBACK: begin
                    pc     <= next_pc;
                    retire <= 1'b1;  // no-ops retire too
                    if (wr_en) begin
                        rout <= exec.result;
                    end
                    state <= ST_DECODE;
                end
                ST_HALTED: begin
                    state <= ST_HALTED;  // only reset leaves
                end
            endcase
        end
    end

endmodule

// File: logic/ultra_small_core.sv
`timescale 1ns/1ns

module ultra_small_core (
    input  logic            w_clk,
    input  logic            r_rst,
    output core_pkg::word_t imem_addr,
    input  core_pkg::word_t imem_data,
    output core_pkg::word_t rout,
    output logic            retire,
    output logic            halt
);
    import core_pkg::*;

    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    logic      use_imm;
    alu_op_e   alu_op;
    logic      is_halt;
    word_t     rdata1;
    word_t     rdata2;
    word_t     next_pc;
    logic      serial_load;
    logic      serial_step;
    logic      rf_we;
    reg_addr_t rf_rd;
    word_t     rf_wdata;

    serial_exec_if exec ();

    instr_decoder u_decoder (
        .instr   (imem_data),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .imm     (imm),
        .use_imm (use_imm),
        .alu_op  (alu_op),
        .is_halt (is_halt)
    );

    reg_file u_reg_file (
        .w_clk  (w_clk),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .rd     (rf_rd),
        .wdata  (rf_wdata)
    );

    serial_alu u_alu (
        .w_clk (w_clk),
        .r_rst (r_rst),
        .exec  (exec.alu)
    );

    pc_serial_adder u_pc_adder (
        .w_clk   (w_clk),
        .r_rst   (r_rst),
        .load    (serial_load),
        .step    (serial_step),
        .pc      (imem_addr),  // program counter drives fetch directly
        .next_pc (next_pc)
    );

    core_sequencer u_sequencer (
        .w_clk       (w_clk),
        .r_rst       (r_rst),
        .exec        (exec.seq),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .rd          (rd),
        .imm         (imm),
        .use_imm     (use_imm),
        .alu_op      (alu_op),
        .is_halt     (is_halt),
        .next_pc     (next_pc),
        .serial_load (serial_load),
        .serial_step (serial_step),
        .pc          (imem_addr),
        .rf_we       (rf_we),
        .rf_rd       (rf_rd),
        .rf_wdata    (rf_wdata),
        .rout        (rout),
        .retire      (retire),
        .halt        (halt)
    );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic w_clk,
    output logic r_rst
);
    localparam int HALF_PERIOD = 20;  // 40 ns period
    localparam int RST_CYCLES  = 3;

    initial begin
        w_clk = 1'b0;
        forever #HALF_PERIOD w_clk = ~w_clk;
    end

    initial begin
        r_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge w_clk);
        #2 r_rst = 1'b0;  // released just after the edge
    end

endmodule

// File: testbench/tb_ultra_small_core.sv
`timescale 1ns/1ns

module tb_ultra_small_core;

    localparam int          N_LOAD      = 15;                  // x1..x15 seeded by addi
    localparam int          N_MIX       = 40;
    localparam int          N_RET       = N_LOAD + N_MIX + 3;  // instructions that retire
    localparam int          N_PROG      = N_RET + 1;           // plus the halt word
    localparam logic [31:0] HALT_ADDR   = 32'(4 * N_RET);
    localparam int          CYC_LIMIT   = 18 * N_PROG + 50;
    localparam int          DRIVE_DELAY = 2;

    logic        w_clk;
    logic        r_rst;
    logic [31:0] imem_addr;
    logic [31:0] imem_data = '0;
    logic [31:0] rout;
    logic        retire;
    logic        halt;

    logic [31:0] imem [64];
    logic [31:0] exp_rout [N_RET];   // rout expected after each retire
    logic        exp_wr [N_RET];
    logic [31:0] model_regs [32];
    logic [31:0] last_rout;
    logic [31:0] lfsr;
    int          n_instr;

    int          ret_idx      = 0;
    int          gap          = 0;
    int          cycles       = 0;
    logic        have_retired = 1'b0;
    logic        prev_rst     = 1'b1;
    logic        prev_halt    = 1'b0;
    logic [31:0] prev_addr    = '0;
    logic [31:0] prev_rout    = '0;

    tb_clock_gen clk_gen (
        .w_clk (w_clk),
        .r_rst (r_rst)
    );

    ultra_small_core uut (
        .w_clk     (w_clk),
        .r_rst     (r_rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .rout      (rout),
        .retire    (retire),
        .halt      (halt)
    );

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // op 0..4 add sub xor or and, op 5..8 addi xori ori andi
    task automatic add_alu(input int op, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [11:0] imm);
        int          fn;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        fn = (op < 5) ? op : ((op == 5) ? 0 : op - 4);
        case (fn)
            0, 1:    f3 = 3'b000;
            2:       f3 = 3'b100;
            3:       f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        f7 = (fn == 1) ? 7'b0100000 : 7'b0000000;
        a  = model_regs[rs1];
        if (op < 5) begin
            imem[n_instr] = {f7, rs2, rs1, f3, rd, 7'b0110011};
            b = model_regs[rs2];
        end else begin
            imem[n_instr] = {imm, rs1, f3, rd, 7'b0010011};
            b = {{20{imm[11]}}, imm};
        end
        case (fn)
            0:       res = a + b;
            1:       res = a - b;
            2:       res = a ^ b;
            3:       res = a | b;
            default: res = a & b;
        endcase
        if (rd != 5'd0) begin
            model_regs[rd] = res;
            last_rout      = res;
        end
        exp_wr[n_instr]   = (rd != 5'd0);
        exp_rout[n_instr] = last_rout;
        n_instr++;
    endtask

    // instruction the core retires without a write
    task automatic add_raw(input logic [31:0] word);
        imem[n_instr]     = word;
        exp_wr[n_instr]   = 1'b0;
        exp_rout[n_instr] = last_rout;
        n_instr++;
    endtask

    task automatic stop_on_error();
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    // memory answers the current address a little after each edge
    always @(posedge w_clk) begin
        #DRIVE_DELAY;
        imem_data <= imem[imem_addr[7:2]];
    end

    always @(posedge w_clk) begin
        prev_rst  <= r_rst;
        prev_halt <= halt;
        prev_addr <= imem_addr;
        prev_rout <= rout;
        if (r_rst) begin
            ret_idx      <= 0;
            gap          <= 0;
            have_retired <= 1'b0;
        end else if (retire) begin
            ret_idx      <= ret_idx + 1;
            gap          <= 1;
            have_retired <= 1'b1;
        end else begin
            gap <= gap + 1;
        end
    end

    always @(posedge w_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYC_LIMIT) begin
            $display("timeout: the core did not halt within %0d cycles", CYC_LIMIT);
            stop_on_error();
        end
    end

    reset_state: assert property (@(posedge w_clk)
        prev_rst && !r_rst |-> !retire && !halt && imem_addr == 32'd0 && rout == 32'd0)
        else begin
            $display("FAIL after reset retire %h halt %h imem_addr %h rout %h",
                     $sampled(retire), $sampled(halt), $sampled(imem_addr), $sampled(rout));
            stop_on_error();
        end

    retire_one_cycle: assert property (@(posedge w_clk) disable iff (r_rst)
        retire |=> !retire)
        else begin
            $display("retire stayed high for more than one cycle");
            stop_on_error();
        end

    retire_spacing: assert property (@(posedge w_clk) disable iff (r_rst)
        retire && have_retired |-> gap == 18)
        else begin
            $display("FAIL retire gap %h expected %h", $sampled(gap), 18);
            stop_on_error();
        end

    pc_advance: assert property (@(posedge w_clk) disable iff (r_rst)
        retire |-> imem_addr == prev_addr + 32'd4)
        else begin
            $display("FAIL imem_addr %h expected %h", $sampled(imem_addr),
                     $sampled(prev_addr) + 32'd4);
            stop_on_error();
        end

    retire_count: assert property (@(posedge w_clk) disable iff (r_rst)
        retire |-> ret_idx < N_RET)
        else begin
            $display("more instructions retired than the program holds");
            stop_on_error();
        end

    rout_written: assert property (@(posedge w_clk) disable iff (r_rst)
        retire && exp_wr[ret_idx] |-> rout == exp_rout[ret_idx])
        else begin
            $display("FAIL rout %h expected %h", $sampled(rout), exp_rout[$sampled(ret_idx)]);
            stop_on_error();
        end

    rout_kept: assert property (@(posedge w_clk) disable iff (r_rst)
        retire && !exp_wr[ret_idx] |-> rout == prev_rout)
        else begin
            $display("FAIL rout %h expected %h", $sampled(rout), $sampled(prev_rout));
            stop_on_error();
        end

    halt_sticky: assert property (@(posedge w_clk) disable iff (r_rst)
        prev_halt |-> halt)
        else begin
            $display("FAIL halt %h expected %h", $sampled(halt), 1'b1);
            stop_on_error();
        end

    halt_quiet: assert property (@(posedge w_clk) disable iff (r_rst)
        halt |-> !retire && imem_addr == HALT_ADDR)
        else begin
            $display("FAIL while halted retire %h imem_addr %h expected %h",
                     $sampled(retire), $sampled(imem_addr), HALT_ADDR);
            stop_on_error();
        end

    halt_after_program: assert property (@(posedge w_clk) disable iff (r_rst)
        halt && !prev_halt |-> ret_idx == N_RET)
        else begin
            $display("FAIL retired count %h expected %h at halt", $sampled(ret_idx), N_RET);
            stop_on_error();
        end

    initial begin
        int          op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        lfsr      = 32'h8cb9_cc9b;
        last_rout = '0;
        n_instr   = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int r = 1; r <= N_LOAD; r++) begin
            imm = 12'(rand_bits(12));
            add_alu(5, 5'(r), 5'd0, 5'd0, imm);  // addi xr, x0, imm
        end
        for (int k = 0; k < N_MIX; k++) begin
            op  = int'(rand_bits(4) % 9);
            rd  = 5'(rand_bits(4));  // x0 included
            rs1 = 5'(rand_bits(4));
            rs2 = 5'(rand_bits(4));
            imm = 12'(rand_bits(12));
            add_alu(op, rd, rs1, rs2, imm);
        end
        add_alu(0, 5'd0, 5'd1, 5'd2, 12'd0);  // add x0, x1, x2 is dropped
        add_raw(32'h0000_2083);               // lw x1, 0(x0) is a no-op here
        add_alu(3, 5'd5, 5'd0, 5'd3, 12'd0);  // or x5, x0, x3 reads x0
        imem[N_RET] = 32'h0000_007f;          // halt

        wait (halt === 1'b1);
        repeat (5) @(posedge w_clk);  // let the halt checks run a few cycles
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: build.f
logic/core_pkg.sv
logic/serial_exec_if.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/serial_alu.sv
logic/pc_serial_adder.sv
logic/core_sequencer.sv
logic/ultra_small_core.sv
testbench/tb_clock_gen.sv
testbench/tb_ultra_small_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ultra_small_core \
    -f build.f -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q '>>> FAIL' sim.log && { echo "simulation failed"; exit 1; } \
    || grep -q '>>> PASS' sim.log || { echo "simulation ended without a result"; exit 1; }
